// File: hdl/l1dc_defs.svh
`ifndef L1DC_DEFS_SVH
`define L1DC_DEFS_SVH

// Physical address width
`define L1DC_ADDR_W 16

// Set index width, 16 sets
`define L1DC_IDX_W 4

// Doubleword offset inside a line, 4 doublewords per line
`define L1DC_WOFF_W 2

// Byte offset inside a doubleword
`define L1DC_BOFF_W 3

// Data geometry
`define L1DC_DATA_W 64
`define L1DC_LINE_W 256

// Tag is whatever the index and both offsets leave over
`define L1DC_TAG_W (`L1DC_ADDR_W - `L1DC_IDX_W - `L1DC_WOFF_W - `L1DC_BOFF_W)

// Derived array sizes
`define L1DC_SETS (1 << `L1DC_IDX_W)
`define L1DC_LINE_BYTES (`L1DC_LINE_W / 8)

`endif

// File: hdl/l1dc_pkg.sv
`include "l1dc_defs.svh"

package l1dc_pkg;

  // Plain data carriers
  typedef logic [`L1DC_DATA_W-1:0]     dword_t;
  typedef logic [`L1DC_LINE_W-1:0]     dcache_line_t;
  typedef logic [`L1DC_IDX_W-1:0]      dcache_idx_t;
  typedef logic [`L1DC_TAG_W-1:0]      dcache_tag_t;
  typedef logic [`L1DC_LINE_BYTES-1:0] line_be_t;

  // Byte address split as the cache sees it
  typedef struct packed {
    dcache_tag_t              tag;
    dcache_idx_t              idx;
    logic [`L1DC_WOFF_W-1:0]  word_off;
    logic [`L1DC_BOFF_W-1:0]  byte_off;
  } paddr_t;

  // Line address exchanged with L2
  typedef struct packed {
    dcache_tag_t tag;
    dcache_idx_t idx;
  } line_addr_t;

  typedef enum logic [1:0] {B, HW, W, DW} store_width_e;

  // What d0 does with the arrays this cycle
  typedef enum logic [2:0] {
    Idle,
    d0_ReadLsq,
    d0_ReadD1,
    d0_WriteStoreD1,
    d0_WriteLineL2,
    d0_ResetLines
  } d0_req_type_e;

  typedef enum logic [2:0] {
    ResetSweep,
    Ready,
    Lookup,
    StoreWrite,
    MissReq,
    MissWait,
    Refill,
    Replay
  } d0_ctrl_state_e;

  typedef struct packed {
    paddr_t       paddr;
    logic         is_store;
    store_width_e store_width;
    dword_t       data;
  } lsq_l1dc_req_t;

  typedef struct packed {
    paddr_t paddr;
    dword_t data;
  } l1dc_lsq_ans_t;

  // Tag array word
  typedef struct packed {
    dcache_tag_t tag;
    logic        valid;
    logic        dirty;
  } tvd_mem_line_t;

  // Contents of the d1 pipeline register
  typedef struct packed {
    d0_req_type_e req_type;
    paddr_t       paddr;
    dword_t       data;
    store_width_e store_width;
    logic         is_store;
  } d1_req_info_t;

  // Miss request, optional victim plus fill address
  typedef struct packed {
    logic         wb;
    line_addr_t   wb_addr;
    dcache_line_t wb_line;
    line_addr_t   fill_addr;
  } l1dc_l2c_req_t;

  typedef struct packed {
    line_addr_t   line_addr;
    dcache_line_t line;
  } l2c_l1dc_ans_t;

  typedef struct packed {
    logic hit;
    logic miss;
    logic victim_dirty;
  } d1_status_t;

endpackage

// File: hdl/d0_ctrl_fsm.sv
`timescale 1ns/1ns

module d0_ctrl_fsm import l1dc_pkg::*; (
  input  logic           clk_i,
  input  logic           arst_n_i,
  // LSQ handshake
  input  logic           lsq_req_valid_i,
  output logic           lsq_req_ready_o,
  output logic           lsq_ans_valid_o,
  // Reset sweep counter
  input  logic           rst_done_i,
  output logic           rst_adv_o,
  // Result of the d1 stage
  input  var d1_status_t d1_status_i,
  input  logic           d1_is_store_i,
  // L2 handshake
  input  logic           l2_req_ready_i,
  output logic           l2_req_valid_o,
  input  logic           l2_ans_valid_i,
  // Request type for the d0 data path
  output d0_req_type_e   d0_req_type_o
);

  d0_ctrl_state_e state_q;
  d0_ctrl_state_e state_d;
  // Store data already in the array, next Lookup only answers
  logic           st_wr_q;

  always_comb begin
    state_d       = state_q;
    d0_req_type_o = Idle;
    unique case (state_q)
      // One set per cycle, last one written while done is high
      ResetSweep: begin
        d0_req_type_o = d0_ResetLines;
        if (rst_done_i) begin
          state_d = Ready;
        end
      end
      Ready: begin
        if (lsq_req_valid_i) begin
          d0_req_type_o = d0_ReadLsq;
          state_d       = Lookup;
        end
      end
      // d1 holds tag compare of the read issued last cycle
      Lookup: begin
        if (st_wr_q) begin
          state_d = Ready;
        end else if (d1_status_i.hit) begin
          state_d = d1_is_store_i ? StoreWrite : Ready;
        end else if (d1_status_i.miss) begin
          state_d = MissReq;
        end
      end
      StoreWrite: begin
        d0_req_type_o = d0_WriteStoreD1;
        state_d       = Lookup;
      end
      // Request held by d1 until L2 takes it
      MissReq: begin
        if (l2_req_ready_i) begin
          state_d = MissWait;
        end
      end
      // Answer is a single pulse, so the line goes in right away
      MissWait: begin
        if (l2_ans_valid_i) begin
          d0_req_type_o = d0_WriteLineL2;
          state_d       = Refill;
        end
      end
      // Fresh line now in the set, d1 still holds the request
      Refill: begin
        state_d = Replay;
      end
      Replay: begin
        d0_req_type_o = d0_ReadD1;
        state_d       = Lookup;
      end
      default: begin
        state_d = ResetSweep;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ResetSweep;
      st_wr_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == StoreWrite) begin
        st_wr_q <= 1'b1;
      end else if (state_q == Lookup) begin
        st_wr_q <= 1'b0;
      end
    end
  end

  assign lsq_req_ready_o = (state_q == Ready);
  assign rst_adv_o       = (state_q == ResetSweep);
  assign l2_req_valid_o  = (state_q == MissReq);
  // Loads answer on hit, stores after their write cycle
  assign lsq_ans_valid_o = (state_q == Lookup) &&
                           (st_wr_q || (d1_status_i.hit && !d1_is_store_i));

  // L2 request is not withdrawn before acceptance
  a_l2_req_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    l2_req_valid_o && !l2_req_ready_i |=> l2_req_valid_o);

  // Answer only in Lookup, and only on its first cycle
  a_ans_in_lookup: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    lsq_ans_valid_o |-> (state_q == Lookup) && ($past(state_q) != Lookup));

endmodule

// File: hdl/rst_sweep_cnt.sv
`timescale 1ns/1ns

module rst_sweep_cnt import l1dc_pkg::*; (
  input  logic        clk_i,
  input  logic        arst_n_i,
  // Step to the next set
  input  logic        adv_i,
  // Set being invalidated this cycle
  output dcache_idx_t rst_idx_o,
  // High while the last set is addressed, stays high afterwards
  output logic        rst_done_o
);

  dcache_idx_t cnt_q;

  // Counts up from zero after reset
  // Saturates on the last index
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (adv_i && !rst_done_o) begin
      cnt_q <= cnt_q + dcache_idx_t'(1);
    end
  end

  assign rst_idx_o = cnt_q;

  // All ones means last set
  assign rst_done_o = &cnt_q;

endmodule

// File: hdl/d0_data_sel_block.sv
`timescale 1ns/1ns

`include "l1dc_defs.svh"

module d0_data_sel_block import l1dc_pkg::*; (
  // Request type chosen by the controller
  input  d0_req_type_e      d0_req_type_i,
  // Sources
  input  var lsq_l1dc_req_t lsq_l1dc_req_i,
  input  var d1_req_info_t  d1_req_i,
  input  var l2c_l1dc_ans_t l2c_l1dc_ans_i,
  input  dcache_idx_t       rst_idx_i,
  // Next d1 register contents
  output d1_req_info_t      reg_out_d_o,
  // Array port
  output dcache_idx_t       dcache_addr_o,
  output logic              dcache_we_o,
  output line_be_t          dcache_be_o,
  output dcache_line_t      dcache_wdata_o,
  output tvd_mem_line_t     dcache_wtvd_o
);

  localparam int DW_IN_LINE = `L1DC_LINE_W / `L1DC_DATA_W;
  localparam int W_IN_LINE  = 2 * DW_IN_LINE;
  localparam int HW_IN_LINE = 2 * W_IN_LINE;
  localparam int B_IN_LINE  = 2 * HW_IN_LINE;
  // Byte position of the store inside the line
  localparam int POS_W = `L1DC_WOFF_W + `L1DC_BOFF_W;

  logic [POS_W-1:0] byte_pos;
  dcache_line_t     st_line;
  line_be_t         st_be;

  assign byte_pos = {d1_req_i.paddr.word_off, d1_req_i.paddr.byte_off};

  // Store data spread over the whole line
  // Enables pick the aligned slot
  always_comb begin
    st_line = {DW_IN_LINE{d1_req_i.data}};
    st_be   = line_be_t'(8'hff) << {byte_pos[POS_W-1:3], 3'b000};
    case (d1_req_i.store_width)
      B: begin
        st_line = {B_IN_LINE{d1_req_i.data[7:0]}};
        st_be   = line_be_t'(1'b1) << byte_pos;
      end
      HW: begin
        st_line = {HW_IN_LINE{d1_req_i.data[15:0]}};
        st_be   = line_be_t'(2'b11) << {byte_pos[POS_W-1:1], 1'b0};
      end
      W: begin
        st_line = {W_IN_LINE{d1_req_i.data[31:0]}};
        st_be   = line_be_t'(4'hf) << {byte_pos[POS_W-1:2], 2'b00};
      end
      default: begin
        // DW uses the defaults above
      end
    endcase
  end

  always_comb begin
    // d1 keeps its request unless a new one comes from the LSQ
    reg_out_d_o          = d1_req_i;
    reg_out_d_o.req_type = d0_req_type_i;
    dcache_addr_o        = d1_req_i.paddr.idx;
    dcache_we_o          = 1'b0;
    dcache_be_o          = '0;
    dcache_wdata_o       = '0;
    dcache_wtvd_o        = '0;
    case (d0_req_type_i)
      // New request from LSQ
      d0_ReadLsq: begin
        reg_out_d_o.paddr       = lsq_l1dc_req_i.paddr;
        reg_out_d_o.data        = lsq_l1dc_req_i.data;
        reg_out_d_o.store_width = lsq_l1dc_req_i.store_width;
        reg_out_d_o.is_store    = lsq_l1dc_req_i.is_store;
        dcache_addr_o           = lsq_l1dc_req_i.paddr.idx;
      end
      // Store on a hit line, line becomes dirty
      d0_WriteStoreD1: begin
        dcache_we_o         = 1'b1;
        dcache_be_o         = st_be;
        dcache_wdata_o      = st_line;
        dcache_wtvd_o.tag   = d1_req_i.paddr.tag;
        dcache_wtvd_o.valid = 1'b1;
        dcache_wtvd_o.dirty = 1'b1;
      end
      // Refill from L2, whole line, clean
      d0_WriteLineL2: begin
        dcache_addr_o       = l2c_l1dc_ans_i.line_addr.idx;
        dcache_we_o         = 1'b1;
        dcache_be_o         = '1;
        dcache_wdata_o      = l2c_l1dc_ans_i.line;
        dcache_wtvd_o.tag   = l2c_l1dc_ans_i.line_addr.tag;
        dcache_wtvd_o.valid = 1'b1;
      end
      // Sweep writes an all-zero tag word, data untouched
      d0_ResetLines: begin
        dcache_addr_o = rst_idx_i;
        dcache_we_o   = 1'b1;
      end
      default: begin
        // Idle and d0_ReadD1 read the held request's set
      end
    endcase
  end

endmodule

// File: hdl/dcache_array.sv
`timescale 1ns/1ns

`include "l1dc_defs.svh"

module dcache_array import l1dc_pkg::*; (
  input  logic              clk_i,
  // Single port, read every cycle
  input  dcache_idx_t       addr_i,
  input  logic              we_i,
  // Data write per byte
  input  line_be_t          be_i,
  input  dcache_line_t      wdata_i,
  // Tag word written whole
  input  var tvd_mem_line_t wtvd_i,
  // Registered read, one cycle after the address
  output dcache_line_t      rdata_o,
  output tvd_mem_line_t     rtvd_o
);

  dcache_line_t  data_mem [`L1DC_SETS];
  tvd_mem_line_t tvd_mem  [`L1DC_SETS];

  // Byte lanes of the data array
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int b = 0; b < `L1DC_LINE_BYTES; b++) begin
        if (be_i[b]) begin
          data_mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      tvd_mem[addr_i] <= wtvd_i;
    end
  end

  // Old contents on read-during-write
  always_ff @(posedge clk_i) begin
    rdata_o <= data_mem[addr_i];
    rtvd_o  <= tvd_mem[addr_i];
  end

  // Writes must land on a known set
  a_we_addr_known: assert property (@(posedge clk_i)
    we_i |-> !$isunknown(addr_i));

endmodule

// File: hdl/d1_hit_block.sv
`timescale 1ns/1ns

`include "l1dc_defs.svh"

module d1_hit_block import l1dc_pkg::*; (
  input  logic              clk_i,
  input  logic              arst_n_i,
  // From d0
  input  var d1_req_info_t  reg_out_d_i,
  // From the arrays, same cycle as the d1 register
  input  dcache_line_t      rdata_i,
  input  var tvd_mem_line_t rtvd_i,
  // Held request, back to d0 and the controller
  output d1_req_info_t      d1_req_o,
  output d1_status_t        d1_status_o,
  // LSQ answer payload
  output l1dc_lsq_ans_t     lsq_ans_o,
  // Miss request to L2
  output l1dc_l2c_req_t     l2_req_o
);

  localparam int DW_IN_LINE = `L1DC_LINE_W / `L1DC_DATA_W;

  d0_req_type_e                type_q;
  d1_req_info_t                info_q;
  l1dc_l2c_req_t               l2_req_q;
  dword_t [DW_IN_LINE-1:0]     line_dw;
  logic                        lookup;
  logic                        tag_match;

  // Request type is the control part
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      type_q <= Idle;
    end else begin
      type_q <= reg_out_d_i.req_type;
    end
  end

  always_ff @(posedge clk_i) begin
    info_q <= reg_out_d_i;
  end

  always_comb begin
    d1_req_o          = info_q;
    d1_req_o.req_type = type_q;
  end

  // Compare only for reads issued to the arrays
  assign lookup    = (type_q == d0_ReadLsq) || (type_q == d0_ReadD1);
  assign tag_match = rtvd_i.valid && (rtvd_i.tag == info_q.paddr.tag);

  assign d1_status_o.hit          = lookup && tag_match;
  assign d1_status_o.miss         = lookup && !tag_match;
  assign d1_status_o.victim_dirty = lookup && !tag_match && rtvd_i.valid && rtvd_i.dirty;

  // Loads return the addressed doubleword, stores echo their data
  assign line_dw        = rdata_i;
  assign lsq_ans_o.paddr = info_q.paddr;
  assign lsq_ans_o.data  = info_q.is_store ? info_q.data : line_dw[info_q.paddr.word_off];

  // Taken on the miss, the set may be reread afterwards
  always_ff @(posedge clk_i) begin
    if (d1_status_o.miss) begin
      l2_req_q.wb            <= d1_status_o.victim_dirty;
      l2_req_q.wb_addr.tag   <= rtvd_i.tag;
      l2_req_q.wb_addr.idx   <= info_q.paddr.idx;
      l2_req_q.wb_line       <= rdata_i;
      l2_req_q.fill_addr.tag <= info_q.paddr.tag;
      l2_req_q.fill_addr.idx <= info_q.paddr.idx;
    end
  end

  assign l2_req_o = l2_req_q;

  // Tag compare of a lookup is never unknown
  // Exactly one of hit and miss follows
  a_hit_xor_miss: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    lookup |-> !$isunknown(d1_status_o) && (d1_status_o.hit ^ d1_status_o.miss));

endmodule

// File: hdl/l1dc_top.sv
`timescale 1ns/1ns

module l1dc_top import l1dc_pkg::*; (
  input  logic              clk_i,
  input  logic              arst_n_i,
  // LSQ request
  input  logic              lsq_req_valid_i,
  output logic              lsq_req_ready_o,
  input  var lsq_l1dc_req_t lsq_req_i,
  // LSQ answer, single-cycle pulse
  output logic              lsq_ans_valid_o,
  output l1dc_lsq_ans_t     lsq_ans_o,
  // L2 request
  output logic              l2_req_valid_o,
  input  logic              l2_req_ready_i,
  output l1dc_l2c_req_t     l2_req_o,
  // L2 answer, single-cycle pulse
  input  logic              l2_ans_valid_i,
  input  var l2c_l1dc_ans_t l2_ans_i
);

  d0_req_type_e  d0_req_type;
  dcache_idx_t   rst_idx;
  logic          rst_done;
  logic          rst_adv;
  d1_status_t    d1_status;
  d1_req_info_t  d1_req;
  d1_req_info_t  reg_out_d;
  dcache_idx_t   dc_addr;
  logic          dc_we;
  line_be_t      dc_be;
  dcache_line_t  dc_wdata;
  tvd_mem_line_t dc_wtvd;
  dcache_line_t  dc_rdata;
  tvd_mem_line_t dc_rtvd;

  d0_ctrl_fsm i_d0_ctrl_fsm (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .lsq_req_valid_i (lsq_req_valid_i),
    .lsq_req_ready_o (lsq_req_ready_o),
    .lsq_ans_valid_o (lsq_ans_valid_o),
    .rst_done_i      (rst_done),
    .rst_adv_o       (rst_adv),
    .d1_status_i     (d1_status),
    .d1_is_store_i   (d1_req.is_store),
    .l2_req_ready_i  (l2_req_ready_i),
    .l2_req_valid_o  (l2_req_valid_o),
    .l2_ans_valid_i  (l2_ans_valid_i),
    .d0_req_type_o   (d0_req_type)
  );

  rst_sweep_cnt i_rst_sweep_cnt (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .adv_i      (rst_adv),
    .rst_idx_o  (rst_idx),
    .rst_done_o (rst_done)
  );

  d0_data_sel_block i_d0_data_sel_block (
    .d0_req_type_i  (d0_req_type),
    .lsq_l1dc_req_i (lsq_req_i),
    .d1_req_i       (d1_req),
    .l2c_l1dc_ans_i (l2_ans_i),
    .rst_idx_i      (rst_idx),
    .reg_out_d_o    (reg_out_d),
    .dcache_addr_o  (dc_addr),
    .dcache_we_o    (dc_we),
    .dcache_be_o    (dc_be),
    .dcache_wdata_o (dc_wdata),
    .dcache_wtvd_o  (dc_wtvd)
  );

  dcache_array i_dcache_array (
    .clk_i   (clk_i),
    .addr_i  (dc_addr),
    .we_i    (dc_we),
    .be_i    (dc_be),
    .wdata_i (dc_wdata),
    .wtvd_i  (dc_wtvd),
    .rdata_o (dc_rdata),
    .rtvd_o  (dc_rtvd)
  );

  d1_hit_block i_d1_hit_block (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .reg_out_d_i (reg_out_d),
    .rdata_i     (dc_rdata),
    .rtvd_i      (dc_rtvd),
    .d1_req_o    (d1_req),
    .d1_status_o (d1_status),
    .lsq_ans_o   (lsq_ans_o),
    .l2_req_o    (l2_req_o)
  );

endmodule

// File: tests/l1dc_tb.sv
`timescale 1ns/1ns

`include "l1dc_defs.svh"

module l1dc_tb import l1dc_pkg::*; ();

  localparam int CLK_PERIOD   = 100;
  localparam int RST_CYCLES   = 4;
  localparam int SWEEP_CYCLES = `L1DC_SETS;
  localparam int NUM_REQ      = 400;
  // 64 lines over 16 sets, four tags compete per set
  localparam int NUM_LINES    = 64;
  localparam int MEM_BYTES    = NUM_LINES * `L1DC_LINE_BYTES;
  localparam int WD_CYCLES    = NUM_REQ * 40 + RST_CYCLES + SWEEP_CYCLES;

  logic          clk_i;
  logic          arst_n_i;
  logic          lsq_req_valid_i;
  logic          lsq_req_ready_o;
  lsq_l1dc_req_t lsq_req_i;
  logic          lsq_ans_valid_o;
  l1dc_lsq_ans_t lsq_ans_o;
  logic          l2_req_valid_o;
  logic          l2_req_ready_i;
  l1dc_l2c_req_t l2_req_o;
  logic          l2_ans_valid_i;
  l2c_l1dc_ans_t l2_ans_i;

  integer        seed = 32'hb3e4;
  // Reference byte memory, follows every accepted store
  logic [7:0]    ref_mem [MEM_BYTES];
  // Backing store of the L2 model
  logic [7:0]    l2_mem  [MEM_BYTES];
  l1dc_lsq_ans_t exp_q [$];
  l1dc_lsq_ans_t exp_ans;
  l1dc_l2c_req_t held_req;
  lsq_l1dc_req_t req;
  paddr_t        cur_paddr;
  int            wb_cnt  = 0;
  int            bp_cnt  = 0;
  int            err_cnt = 0;
  int            st_width_cnt [4] = '{0, 0, 0, 0};

  l1dc_top uut (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .lsq_req_valid_i (lsq_req_valid_i),
    .lsq_req_ready_o (lsq_req_ready_o),
    .lsq_req_i       (lsq_req_i),
    .lsq_ans_valid_o (lsq_ans_valid_o),
    .lsq_ans_o       (lsq_ans_o),
    .l2_req_valid_o  (l2_req_valid_o),
    .l2_req_ready_i  (l2_req_ready_i),
    .l2_req_o        (l2_req_o),
    .l2_ans_valid_i  (l2_ans_valid_i),
    .l2_ans_i        (l2_ans_i)
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Fill pattern, every address bit counts
  function automatic logic [7:0] fill_byte(int addr);
    return 8'(addr ^ (addr >> 8) ^ 8'h96);
  endfunction

  function automatic logic line_in_range(line_addr_t la);
    return int'(la) < NUM_LINES;
  endfunction

  // Doubleword holding the byte address, byte offset ignored
  function automatic dword_t ref_dword(paddr_t a);
    int     base;
    dword_t d;
    base = int'(a) & ~7;
    for (int i = 0; i < 8; i++) begin
      d[i*8 +: 8] = ref_mem[base + i];
    end
    return d;
  endfunction

  function automatic dcache_line_t ref_line(line_addr_t la);
    int           base;
    dcache_line_t l;
    base = int'(la) * `L1DC_LINE_BYTES;
    for (int b = 0; b < `L1DC_LINE_BYTES; b++) begin
      l[b*8 +: 8] = ref_mem[base + b];
    end
    return l;
  endfunction

  function automatic dcache_line_t l2_line(line_addr_t la);
    int           base;
    dcache_line_t l;
    base = int'(la) * `L1DC_LINE_BYTES;
    for (int b = 0; b < `L1DC_LINE_BYTES; b++) begin
      l[b*8 +: 8] = l2_mem[base + b];
    end
    return l;
  endfunction

  task automatic stop_run();
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic fail_plain(input string what);
    $display("Failure at %0t ns: %s", $time, what);
    stop_run();
  endtask

  task automatic check_dword(input string name, input dword_t got, input dword_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_line(input string name, input dcache_line_t got,
                            input dcache_line_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_paddr(input string name, input paddr_t got, input paddr_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_l2_req(input string name, input l1dc_l2c_req_t got,
                              input l1dc_l2c_req_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  // Ready low for the whole sweep, nothing else may move
  task automatic check_sweep();
    int low_cnt;
    low_cnt = 0;
    @(negedge clk_i);
    while (!lsq_req_ready_o) begin
      if (l2_req_valid_o || lsq_ans_valid_o) begin
        fail_plain("L2 request or LSQ answer raised during the reset sweep");
      end
      low_cnt++;
      if (low_cnt > SWEEP_CYCLES) begin
        fail_plain("LSQ ready did not rise after the reset sweep");
      end
      @(negedge clk_i);
    end
    if (low_cnt != SWEEP_CYCLES) begin
      fail_plain($sformatf("LSQ ready low for %0d cycles after reset, expected %0d",
                           low_cnt, SWEEP_CYCLES));
    end
  endtask

  // Aligned stores, loads with any byte offset
  task automatic make_request(output lsq_l1dc_req_t r);
    logic [5:0]   line;
    logic [1:0]   woff;
    logic [2:0]   boff;
    store_width_e sw;
    line       = 6'($random(seed));
    woff       = 2'($random(seed));
    boff       = 3'($random(seed));
    sw         = store_width_e'(2'($random(seed)));
    r.is_store = 1'($random(seed));
    if (r.is_store) begin
      boff = 3'((boff >> int'(sw)) << int'(sw));
    end
    r.paddr       = paddr_t'({5'b0, line, woff, boff});
    r.store_width = sw;
    r.data        = {$random(seed), $random(seed)};
  endtask

  task automatic issue_request(input lsq_l1dc_req_t r);
    l1dc_lsq_ans_t exp;
    int            base;
    @(posedge clk_i);
    lsq_req_valid_i <= 1'b1;
    lsq_req_i       <= r;
    do begin
      @(negedge clk_i);
    end while (!lsq_req_ready_o);
    // Accepted at this edge
    @(posedge clk_i);
    lsq_req_valid_i <= 1'b0;
    cur_paddr = r.paddr;
    exp.paddr = r.paddr;
    exp.data  = r.is_store ? r.data : ref_dword(r.paddr);
    exp_q.push_back(exp);
    if (r.is_store) begin
      base = int'(r.paddr);
      for (int i = 0; i < (1 << int'(r.store_width)); i++) begin
        ref_mem[base + i] = r.data[i*8 +: 8];
      end
      st_width_cnt[int'(r.store_width)]++;
    end
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  // Writeback goes in before the fill line is read
  task automatic answer_l2(input l1dc_l2c_req_t r);
    int            base;
    int            delay;
    l2c_l1dc_ans_t ans;
    if (r.wb) begin
      if (!line_in_range(r.wb_addr)) begin
        fail_plain("L2 writeback address outside the tested range");
      end
      check_line("l2_req_o.wb_line", r.wb_line, ref_line(r.wb_addr));
      base = int'(r.wb_addr) * `L1DC_LINE_BYTES;
      for (int b = 0; b < `L1DC_LINE_BYTES; b++) begin
        l2_mem[base + b] = r.wb_line[b*8 +: 8];
      end
      wb_cnt++;
    end
    check_paddr("l2_req_o.fill_addr", {r.fill_addr, cur_paddr.word_off, cur_paddr.byte_off},
                cur_paddr);
    ans.line_addr = r.fill_addr;
    ans.line      = l2_line(r.fill_addr);
    delay = int'($unsigned($random(seed)) % 4);
    repeat (delay) @(posedge clk_i);
    @(posedge clk_i);
    l2_ans_valid_i <= 1'b1;
    l2_ans_i       <= ans;
    @(posedge clk_i);
    l2_ans_valid_i <= 1'b0;
  endtask

  // L2 model, random back-pressure then one ready pulse
  initial begin
    int delay;
    forever begin
      @(negedge clk_i);
      if (l2_req_valid_o) begin
        held_req = l2_req_o;
        delay = int'($unsigned($random(seed)) % 4);
        if (delay > 0) begin
          bp_cnt++;
        end
        repeat (delay + 1) begin
          @(negedge clk_i);
          if (!l2_req_valid_o) begin
            fail_plain("L2 request dropped before it was accepted");
          end
          check_l2_req("l2_req_o", l2_req_o, held_req);
          if (delay == 0) begin
            break;
          end
          delay--;
        end
        @(posedge clk_i);
        l2_req_ready_i <= 1'b1;
        @(negedge clk_i);
        check_l2_req("l2_req_o", l2_req_o, held_req);
        @(posedge clk_i);
        l2_req_ready_i <= 1'b0;
        answer_l2(held_req);
      end
    end
  end

  // LSQ answer monitor, one pulse per accepted request
  always @(negedge clk_i) begin
    if (lsq_req_ready_o && exp_q.size() != 0) begin
      fail_plain("LSQ ready high while a request is outstanding");
    end
    if (lsq_ans_valid_o) begin
      if (exp_q.size() == 0) begin
        fail_plain("LSQ answer without an accepted request");
      end else begin
        exp_ans = exp_q.pop_front();
        check_paddr("lsq_ans_o.paddr", lsq_ans_o.paddr, exp_ans.paddr);
        check_dword("lsq_ans_o.data", lsq_ans_o.data, exp_ans.data);
      end
    end
  end

  initial begin
    #(WD_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the cache stopped answering", WD_CYCLES);
    stop_run();
  end

  initial begin
    arst_n_i        = 1'b0;
    lsq_req_valid_i = 1'b0;
    lsq_req_i       = '0;
    l2_req_ready_i  = 1'b0;
    l2_ans_valid_i  = 1'b0;
    l2_ans_i        = '0;
    for (int a = 0; a < MEM_BYTES; a++) begin
      ref_mem[a] = fill_byte(a);
      l2_mem[a]  = fill_byte(a);
    end
    repeat (RST_CYCLES) @(posedge clk_i);
    arst_n_i <= 1'b1;
    check_sweep();
    for (int n = 0; n < NUM_REQ; n++) begin
      make_request(req);
      issue_request(req);
    end
    repeat (4) @(negedge clk_i);
    // Stimulus must have reached every case
    for (int w = 0; w < 4; w++) begin
      if (st_width_cnt[w] == 0) begin
        $display("No store of width code %0d was issued", w);
        err_cnt++;
      end
    end
    if (wb_cnt == 0) begin
      $display("No dirty line was written back to L2");
      err_cnt++;
    end
    if (bp_cnt == 0) begin
      $display("L2 never held its ready low against a request");
      err_cnt++;
    end
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  end

endmodule

// File: l1dc_top.f
+incdir+hdl
hdl/l1dc_pkg.sv
hdl/d0_ctrl_fsm.sv
hdl/rst_sweep_cnt.sv
hdl/d0_data_sel_block.sv
hdl/dcache_array.sv
hdl/d1_hit_block.sv
hdl/l1dc_top.sv
tests/l1dc_tb.sv
